// File: nn_pkg.sv
package nn_pkg;

	// ============================================================
	// Single precision word
	// ============================================================

	typedef union packed {
		logic [31:0] bits;
		struct packed {
			logic        sign;
			logic [7:0]  exponent;
			logic [22:0] mantissa;
		} fields;
	} fp32_u;

	// ============================================================
	// Node shape and weights
	// ============================================================

	localparam int NODE_INPUTS = 30;
	localparam int IDX_W       = 5;

	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NODE_INPUTS - 1);

	localparam logic [31:0] W_POS = 32'h3E877DDF;  // About 0.2646.
	localparam logic [31:0] W_NEG = 32'hBE877DDF;

	// Even positions positive, odd positions negative.
	localparam fp32_u NODE_WEIGHTS [NODE_INPUTS] = '{
		W_POS, W_NEG,  // 0, 1.
		W_POS, W_NEG,
		W_POS, W_NEG,
		W_POS, W_NEG,
		W_POS, W_NEG,
		W_POS, W_NEG,  // 10, 11.
		W_POS, W_NEG,
		W_POS, W_NEG,
		W_POS, W_NEG,
		W_POS, W_NEG,
		W_POS, W_NEG,  // 20, 21.
		W_POS, W_NEG,
		W_POS, W_NEG,
		W_POS, W_NEG,
		W_POS, W_NEG   // 28, 29.
	};

endpackage

// File: mac_if.sv
`timescale 1ns/1ps

interface mac_if;

	logic          valid;   // One cycle per element.
	nn_pkg::fp32_u act;
	nn_pkg::fp32_u weight;
	logic          first;   // Position 0.
	logic          last;    // Position 29.

	modport seq (
		output valid,
		output act,
		output weight,
		output first,
		output last
	);

	modport dp (
		input valid,
		input act,
		input weight,
		input first,
		input last
	);

endinterface

// File: float_mult.sv
`timescale 1ns/1ps

module float_mult (
	input  nn_pkg::fp32_u x,
	input  nn_pkg::fp32_u y,
	output nn_pkg::fp32_u z
);

	logic              sign;
	logic              zero_in;
	logic [23:0]       sig_x;
	logic [23:0]       sig_y;
	logic [47:0]       prod;
	logic signed [9:0] exp_sum;
	logic signed [9:0] exp_res;
	logic [22:0]       man_res;

	// ============================================================
	// Sign, exponent and significand product
	// ============================================================

	assign sign    = x.fields.sign ^ y.fields.sign;
	assign zero_in = (x.fields.exponent == 8'd0) || (y.fields.exponent == 8'd0);
	assign sig_x   = {1'b1, x.fields.mantissa};
	assign sig_y   = {1'b1, y.fields.mantissa};
	assign prod    = sig_x * sig_y;   // 1.x times 1.y lies in [1, 4).

	assign exp_sum = $signed({2'b00, x.fields.exponent})
	               + $signed({2'b00, y.fields.exponent})
	               - 10'sd127;

	// One place of normalization at most.
	always_comb
	begin
		if (prod[47])
		begin
			man_res = prod[46:24];
			exp_res = exp_sum + 10'sd1;
		end
		else
		begin
			man_res = prod[45:23];
			exp_res = exp_sum;
		end
	end

	// ============================================================
	// Packing
	// ============================================================

	always_comb
	begin
		if (zero_in)
			z.bits = 32'd0;
		else if (exp_res <= 10'sd0)
			z.bits = 32'd0;                       // Flush to +0.
		else if (exp_res >= 10'sd255)
			z.bits = {sign, 8'hff, 23'd0};        // Infinity.
		else
			z.bits = {sign, exp_res[7:0], man_res};
	end

endmodule

// File: float_adder.sv
`timescale 1ns/1ps

module float_adder (
	input  nn_pkg::fp32_u a,
	input  nn_pkg::fp32_u b,
	output nn_pkg::fp32_u sum
);

	nn_pkg::fp32_u     big;
	nn_pkg::fp32_u     little;
	logic              a_zero;
	logic              b_zero;
	logic [7:0]        exp_diff;
	logic [23:0]       sig_big;
	logic [23:0]       sig_little;
	logic [23:0]       sig_align;
	logic [24:0]       sig_raw;
	logic [4:0]        lz;
	logic [23:0]       sig_norm;
	logic signed [9:0] exp_res;
	logic [22:0]       man_res;

	assign a_zero = (a.fields.exponent == 8'd0);
	assign b_zero = (b.fields.exponent == 8'd0);

	// ============================================================
	// Ordering and alignment
	// ============================================================

	always_comb
	begin
		if (a.bits[30:0] >= b.bits[30:0])  // Exponent and mantissa compare as one field.
		begin
			big    = a;
			little = b;
		end
		else
		begin
			big    = b;
			little = a;
		end
	end

	assign exp_diff   = big.fields.exponent - little.fields.exponent;
	assign sig_big    = (big.fields.exponent == 8'd0) ? 24'd0 : {1'b1, big.fields.mantissa};
	assign sig_little = (little.fields.exponent == 8'd0) ? 24'd0
	                  : {1'b1, little.fields.mantissa};
	assign sig_align  = sig_little >> exp_diff;  // Shifted-out bits are lost.

	// Magnitude order keeps the difference non-negative.
	assign sig_raw = (big.fields.sign == little.fields.sign)
	               ? {1'b0, sig_big} + {1'b0, sig_align}
	               : {1'b0, sig_big} - {1'b0, sig_align};

	// ============================================================
	// Normalization
	// ============================================================

	always_comb
	begin
		lz = 5'd0;
		for (int i = 0; i < 24; i++)
		begin
			if (sig_raw[i])
				lz = 5'(23 - i);  // Highest set bit wins.
		end
	end

	assign sig_norm = sig_raw[23:0] << lz;

	always_comb
	begin
		if (sig_raw[24])
		begin
			man_res = sig_raw[23:1];  // Carry out.
			exp_res = $signed({2'b00, big.fields.exponent}) + 10'sd1;
		end
		else
		begin
			man_res = sig_norm[22:0];
			exp_res = $signed({2'b00, big.fields.exponent}) - $signed({5'd0, lz});
		end
	end

	always_comb
	begin
		if (sig_raw == 25'd0)
			sum.bits = 32'd0;                              // Exact cancellation.
		else if (exp_res <= 10'sd0)
			sum.bits = 32'd0;
		else if (exp_res >= 10'sd255)
			sum.bits = {big.fields.sign, 8'hff, 23'd0};
		else
			sum.bits = {big.fields.sign, exp_res[7:0], man_res};

		if (a_zero && b_zero)
		begin
			a_zero_sum: assert (sum.bits == 32'd0)
				else $error("Two zero operands did not give +0.");
		end
	end

endmodule

// File: node_seq.sv
`timescale 1ns/1ps

module node_seq (
	input  logic          clk,
	input  logic          arst_n,
	input  logic          in_valid,
	input  nn_pkg::fp32_u in_data,
	mac_if.seq            mac
);

	logic [nn_pkg::IDX_W-1:0] idx;
	logic                     at_last;

	assign at_last = (idx == nn_pkg::LAST_IDX);

	// Position counter and element flags.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			idx       <= '0;
			mac.valid <= 1'b0;
			mac.first <= 1'b0;
			mac.last  <= 1'b0;
		end
		else
		begin
			mac.valid <= in_valid;
			if (in_valid)
			begin
				idx       <= at_last ? '0 : idx + 1'b1;  // Wrap after 29.
				mac.first <= (idx == '0);
				mac.last  <= at_last;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			mac.act    <= in_data;
			mac.weight <= nn_pkg::NODE_WEIGHTS[idx];
		end
	end

	a_in_valid_known: assert property (
		@(posedge clk) disable iff (!arst_n) !$isunknown(in_valid)
	) else $error("in_valid is unknown out of reset.");

endmodule

// File: node_datapath.sv
`timescale 1ns/1ps

module node_datapath (
	input  logic          clk,
	input  logic          arst_n,
	mac_if.dp             mac,
	output logic          out_valid,
	output nn_pkg::fp32_u out_data
);

	nn_pkg::fp32_u prod;
	nn_pkg::fp32_u prod_q;
	nn_pkg::fp32_u acc;
	nn_pkg::fp32_u sum;
	nn_pkg::fp32_u acc_next;
	logic          prod_valid;
	logic          prod_first;
	logic          prod_last;

	float_mult u_float_mult (
		.x (mac.act),
		.y (mac.weight),
		.z (prod)
	);

	float_adder u_float_adder (
		.a   (acc),
		.b   (prod_q),
		.sum (sum)
	);

	assign acc_next = prod_first ? prod_q : sum;  // First element restarts the sum.

	// ============================================================
	// Product stage, then accumulate stage
	// ============================================================

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			prod_valid <= 1'b0;
			prod_first <= 1'b0;
			prod_last  <= 1'b0;
			out_valid  <= 1'b0;
			out_data   <= '0;
		end
		else
		begin
			prod_valid <= mac.valid;
			prod_first <= mac.first;
			prod_last  <= mac.last;
			out_valid  <= prod_valid && prod_last;
			if (prod_valid && prod_last)
				out_data <= acc_next.fields.sign ? '0 : acc_next;  // Rectifier.
		end
	end

	always_ff @(posedge clk)
	begin
		if (mac.valid)
			prod_q <= prod;
		if (prod_valid)
			acc <= acc_next;
	end

	a_out_nonneg: assert property (
		@(posedge clk) disable iff (!arst_n) !out_data.fields.sign
	) else $error("Node output carries a sign bit.");

endmodule

// File: neuron_top.sv
`timescale 1ns/1ps

module neuron_top (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        in_valid,
	input  logic [31:0] in_data,
	output logic        out_valid,
	output logic [31:0] out_data
);

	mac_if mac ();

	// Stream position and weight select.
	node_seq u_node_seq (
		.clk      (clk),
		.arst_n   (arst_n),
		.in_valid (in_valid),
		.in_data  (in_data),
		.mac      (mac.seq)
	);

	// Multiply, accumulate and rectify.
	node_datapath u_node_datapath (
		.clk       (clk),
		.arst_n    (arst_n),
		.mac       (mac.dp),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

endmodule

// File: tb_neuron_top.sv
`timescale 1ns/1ps

module tb_neuron_top;

	localparam int          NUM_VEC        = 8;
	localparam int          WORDS_PER_VEC  = nn_pkg::NODE_INPUTS + 1;  // Activations, then result.
	localparam int          STIM_WORDS     = NUM_VEC * WORDS_PER_VEC;
	localparam int          TIMEOUT_CYCLES = NUM_VEC * nn_pkg::NODE_INPUTS * 4 + 50;
	localparam logic [31:0] SEED           = 32'h0e2e2843;

	logic        clk = 1'b0;
	logic        arst_n;
	logic        in_valid;
	logic [31:0] in_data;
	logic        out_valid;
	logic [31:0] out_data;

	logic [31:0]   stim_mem [STIM_WORDS];
	nn_pkg::fp32_u exp_q [$];
	nn_pkg::fp32_u held_data;     // Word the DUT should be holding.
	logic [2:0]    last_pipe;     // Element 29 accepted, by edges since.
	logic          drive_last;
	logic [31:0]   rng;
	int            gap;
	int            cycle_count;

	neuron_top u_neuron_top (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

	always #20 clk = ~clk;

	// ============================================================
	// Compare tasks and random numbers
	// ============================================================

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "Stopped at first error.");
	endtask

	task automatic check_data(input string name, input nn_pkg::fp32_u got,
		input nn_pkg::fp32_u want);
		if (got.bits !== want.bits)
			report_error($sformatf("FAIL %s at %0t: expected %h, got %h",
				name, $time, want.bits, got.bits));
	endtask

	task automatic check_strobe(input string name, input logic got, input logic want);
		if (got !== want)
			report_error($sformatf("FAIL %s at %0t: expected %h, got %h",
				name, $time, want, got));
	endtask

	function automatic logic [31:0] next_rand(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// ============================================================
	// Monitors
	// ============================================================

	// Result is due two edges after the accepting edge.
	always @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			last_pipe <= '0;
		else
			last_pipe <= {last_pipe[1:0], in_valid && drive_last};
	end

	always @(negedge clk)
	begin
		check_strobe("out_valid", out_valid, last_pipe[2]);
		if (out_valid)
		begin
			if (exp_q.size() == 0)
				report_error("A result arrived with no vector pending.");
			else
				held_data = exp_q.pop_front();
		end
		check_data("out_data", out_data, held_data);  // Also covers the hold between results.
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES)
			report_error($sformatf("Run did not finish within %0d cycles.", TIMEOUT_CYCLES));
	end

	// ============================================================
	// Stimulus
	// ============================================================

	initial
	begin
		arst_n       = 1'b0;
		in_valid     = 1'b0;
		in_data      = '0;
		drive_last   = 1'b0;
		held_data    = '0;
		rng          = SEED;
		cycle_count  = 0;

		for (int i = 0; i < STIM_WORDS; i++)
			stim_mem[i] = 32'hFFFF_0000 | 32'(i);  // NaN marker, one per address.
		$readmemh("neuron_stim.txt", stim_mem);
		if (stim_mem[STIM_WORDS-1] == (32'hFFFF_0000 | 32'(STIM_WORDS - 1)))
			report_error("Stimulus file is missing or shorter than expected.");

		repeat (4) @(negedge clk);
		arst_n = 1'b1;

		for (int v = 0; v < NUM_VEC; v++)
		begin
			for (int e = 0; e < nn_pkg::NODE_INPUTS; e++)
			begin
				rng = next_rand(rng);
				gap = (e == 0 && v % 2 == 1) ? 0 : int'(rng[31:30]);  // Odd vectors follow at once.
				repeat (gap)
				begin
					@(negedge clk);
					in_valid   = 1'b0;
					in_data    = rng;  // Idle data must be ignored.
					drive_last = 1'b0;
				end
				@(negedge clk);
				in_valid   = 1'b1;
				in_data    = stim_mem[v * WORDS_PER_VEC + e];
				drive_last = (e == nn_pkg::NODE_INPUTS - 1);
				if (drive_last)
					exp_q.push_back(stim_mem[v * WORDS_PER_VEC + nn_pkg::NODE_INPUTS]);
			end
		end

		@(negedge clk);
		in_valid   = 1'b0;
		drive_last = 1'b0;
		while (exp_q.size() != 0)
			@(negedge clk);
		repeat (4) @(negedge clk);  // Strobe stays low once the stream stops.

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// File: neuron_stim.txt
// Columns: activations 0 to 29, then the expected node output, all single precision hex.
// One vector per line, products summed in index order with truncation, then rectified.
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
40000000 3F800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3E877DE0
3F800000 00000000 3F800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3F077DDF
00000000 3F800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
3F800000 3F800000 3F800000 3F800000 3F800000 3F800000 3F800000 3F800000 3F800000 3F800000 3F800000 3F800000 3F800000 3F800000 3F800000 3F800000 3F800000 3F800000 3F800000 3F800000 3F800000 3F800000 3F800000 3F800000 3F800000 3F800000 3F800000 3F800000 3F800000 3F800000 00000000
3FC00000 3F000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3E877DDF
7F7FFFFF FF7FFFFF 7F7FFFFF FF7FFFFF 7F7FFFFF FF7FFFFF 7F7FFFFF FF7FFFFF 7F7FFFFF FF7FFFFF 7F7FFFFF FF7FFFFF 7F7FFFFF FF7FFFFF 7F7FFFFF FF7FFFFF 7F7FFFFF FF7FFFFF 7F7FFFFF FF7FFFFF 7F7FFFFF FF7FFFFF 7F7FFFFF FF7FFFFF 7F7FFFFF FF7FFFFF 7F7FFFFF FF7FFFFF 7F7FFFFF FF7FFFFF 7F800000
FF7FFFFF 7F7FFFFF FF7FFFFF 7F7FFFFF FF7FFFFF 7F7FFFFF FF7FFFFF 7F7FFFFF FF7FFFFF 7F7FFFFF FF7FFFFF 7F7FFFFF FF7FFFFF 7F7FFFFF FF7FFFFF 7F7FFFFF FF7FFFFF 7F7FFFFF FF7FFFFF 7F7FFFFF FF7FFFFF 7F7FFFFF FF7FFFFF 7F7FFFFF FF7FFFFF 7F7FFFFF FF7FFFFF 7F7FFFFF FF7FFFFF 7F7FFFFF 00000000

// File: flist.f
nn_pkg.sv
mac_if.sv
float_mult.sv
float_adder.sv
node_seq.sv
node_datapath.sv
neuron_top.sv
tb_neuron_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the neuron node testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f flist.f --top-module tb_neuron_top -o sim_neuron
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build returned status $status"
	exit $status
fi

./obj_dir/sim_neuron
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation run returned status $status"
	exit $status
fi

exit 0
